//--- Bender.yml
package:
  name: rv_slice

sources:
  - rv_pkg.sv
  - rv_decoder.sv
  - rv_id_ex.sv
  - rv_alu.sv
  - rv_branch_unit.sv
  - rv_ex_result.sv
  - rv_id_ex_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rv_id_ex_tb.sv

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::ctrl_w-1:0]  ctrl_i,
    input  logic [rv_pkg::funct_w-1:0] funct_i,
    input  logic [rv_pkg::xlen-1:0]    rs1_data_i,
    input  logic [rv_pkg::xlen-1:0]    rs2_data_i,
    input  logic [rv_pkg::xlen-1:0]    imm_i,
    output logic [rv_pkg::xlen-1:0]    result_o
);

    import rv_pkg::*;

    alu_op_e         op;
    logic [xlen-1:0] op_b;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    assign funct3 = funct_i[funct3_lo +: 3];
    assign funct7 = funct_i[funct7_hi -: 7];
    assign op_b   = ctrl_i[ctrl_alu_src] ? imm_i : rs2_data_i;

    ////////////////////
    // Operation select
    ////////////////////
    always_comb begin
        if (ctrl_i[ctrl_lui]) begin
            op = PASS_B;
        end else if (ctrl_i[ctrl_mem_read] || ctrl_i[ctrl_mem_write] || ctrl_i[ctrl_jalr]) begin
            op = ADD; // Address generation
        end else if (ctrl_i[ctrl_branch]) begin
            op = SUB;
        end else begin
            case (funct3)
                3'b000:  op = (!ctrl_i[ctrl_alu_src] && funct7[5]) ? SUB : ADD;
                3'b001:  op = SLL;
                3'b010:  op = SLT;
                3'b011:  op = SLTU;
                3'b100:  op = XOR;
                3'b101:  op = funct7[5] ? SRA : SRL; // Also true for the immediate form
                3'b110:  op = OR;
                default: op = AND;
            endcase
        end
    end

    always_comb begin
        case (op)
            ADD:     result_o = rs1_data_i + op_b;
            SUB:     result_o = rs1_data_i - op_b;
            SLL:     result_o = rs1_data_i << op_b[4:0];
            SLT:     result_o = {{(xlen-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
            SLTU:    result_o = {{(xlen-1){1'b0}}, rs1_data_i < op_b};
            XOR:     result_o = rs1_data_i ^ op_b;
            SRL:     result_o = rs1_data_i >> op_b[4:0];
            SRA:     result_o = $unsigned($signed(rs1_data_i) >>> op_b[4:0]);
            OR:      result_o = rs1_data_i | op_b;
            AND:     result_o = rs1_data_i & op_b;
            PASS_B:  result_o = op_b;
            default: result_o = '0;
        endcase
    end

endmodule

//--- rv_branch_unit.sv
`timescale 1ns/1ps

module rv_branch_unit (
    input  logic [rv_pkg::ctrl_w-1:0]  ctrl_i,
    input  logic                       jump_i,
    input  logic [rv_pkg::funct_w-1:0] funct_i,
    input  logic [rv_pkg::xlen-1:0]    rs1_data_i,
    input  logic [rv_pkg::xlen-1:0]    rs2_data_i,
    input  logic [rv_pkg::xlen-1:0]    imm_i,
    input  logic [rv_pkg::xlen-1:0]    pc_plus_i,
    output logic                       taken_o,
    output logic [rv_pkg::xlen-1:0]    target_o
);

    import rv_pkg::*;

    logic            cond;
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    always_comb begin
        case (funct_i[funct3_lo +: 3])
            3'b000:  cond = (rs1_data_i == rs2_data_i);
            3'b001:  cond = (rs1_data_i != rs2_data_i);
            3'b100:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            3'b101:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            3'b110:  cond = (rs1_data_i < rs2_data_i);
            3'b111:  cond = (rs1_data_i >= rs2_data_i);
            default: cond = 1'b0; // Reserved branch encodings never fire
        endcase
    end

    assign taken_o = jump_i || (ctrl_i[ctrl_branch] && cond);

    // Branches and JAL are PC relative, the PC is recovered from pc_plus
    assign base = ctrl_i[ctrl_jalr] ? rs1_data_i : pc_plus_i - 32'd4;
    assign sum  = base + imm_i;

    assign target_o = ctrl_i[ctrl_jalr] ? {sum[xlen-1:1], 1'b0} : sum;

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0]       instr_i,
    input  logic [rv_pkg::xlen-1:0]       pc_i,
    output logic [rv_pkg::ctrl_w-1:0]     ctrl_o,
    output logic                          jump_o,
    output logic [rv_pkg::xlen-1:0]       pc_plus_o,
    output logic [rv_pkg::xlen-1:0]       imm_o,
    output logic [rv_pkg::funct_w-1:0]    funct_o,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr_o,
    output logic [rv_pkg::reg_addr_w-1:0] rd_addr_o
);

    import rv_pkg::*;

    opcode_e          opcode;
    logic [xlen-1:0]  imm_itype;
    logic [xlen-1:0]  imm_stype;
    logic [xlen-1:0]  imm_btype;
    logic [xlen-1:0]  imm_utype;
    logic [xlen-1:0]  imm_jtype;

    assign opcode = opcode_e'(instr_i[6:0]);

    // Register addresses and funct are taken straight from the fixed fields
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];
    assign funct_o    = {instr_i[31:25], instr_i[14:12]};
    assign pc_plus_o  = pc_i + 32'd4;

    ////////////////////
    // Immediates
    ////////////////////
    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_stype = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    ////////////////////
    // Control
    ////////////////////
    always_comb begin
        ctrl_o = '0;
        jump_o = 1'b0;
        imm_o  = '0;
        case (opcode)
            OP: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
            end
            OP_IMM: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
                ctrl_o[ctrl_alu_src]   = 1'b1;
                imm_o                  = imm_itype;
            end
            LUI: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
                ctrl_o[ctrl_alu_src]   = 1'b1;
                ctrl_o[ctrl_lui]       = 1'b1;
                imm_o                  = imm_utype;
            end
            LOAD: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
                ctrl_o[ctrl_mem_read]  = 1'b1;
                ctrl_o[ctrl_alu_src]   = 1'b1;
                imm_o                  = imm_itype;
            end
            STORE: begin
                ctrl_o[ctrl_mem_write] = 1'b1;
                ctrl_o[ctrl_alu_src]   = 1'b1;
                imm_o                  = imm_stype;
            end
            BRANCH: begin
                ctrl_o[ctrl_branch] = 1'b1;
                imm_o               = imm_btype;
            end
            JAL: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
                jump_o                 = 1'b1;
                imm_o                  = imm_jtype;
            end
            JALR: begin
                ctrl_o[ctrl_reg_write] = 1'b1;
                ctrl_o[ctrl_alu_src]   = 1'b1;
                ctrl_o[ctrl_jalr]      = 1'b1;
                jump_o                 = 1'b1;
                imm_o                  = imm_itype;
            end
            default: ; // Anything else becomes a bubble
        endcase
    end

endmodule

//--- rv_ex_result.sv
`timescale 1ns/1ps

module rv_ex_result (
    input  logic [rv_pkg::ctrl_w-1:0]     ctrl_i,
    input  logic                          jump_i,
    input  logic [rv_pkg::xlen-1:0]       alu_result_i,
    input  logic [rv_pkg::xlen-1:0]       pc_plus_i,
    input  logic [rv_pkg::xlen-1:0]       rs2_data_i,
    input  logic [rv_pkg::xlen-1:0]       branch_target_i,
    input  logic                          taken_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_addr_i,
    output logic [rv_pkg::xlen-1:0]       wb_data_o,
    output logic [rv_pkg::xlen-1:0]       mem_addr_o,
    output logic [rv_pkg::xlen-1:0]       store_data_o,
    output logic [rv_pkg::xlen-1:0]       redirect_pc_o,
    output logic                          rd_we_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          redirect_o,
    output logic [rv_pkg::reg_addr_w-1:0] rd_addr_o
);

    import rv_pkg::*;

    // Jumps write the link address
    assign wb_data_o = jump_i ? pc_plus_i : alu_result_i;
    assign rd_addr_o = rd_addr_i;
    assign rd_we_o   = ctrl_i[ctrl_reg_write] && (rd_addr_i != '0); // x0 is never written

    assign mem_addr_o   = alu_result_i;
    assign store_data_o = rs2_data_i;
    assign mem_read_o   = ctrl_i[ctrl_mem_read];
    assign mem_write_o  = ctrl_i[ctrl_mem_write];

    // Target is only driven out while redirecting, so a bubble reads as zero
    assign redirect_o    = taken_i;
    assign redirect_pc_o = taken_i ? branch_target_i : '0;

    redirect_align_a: assert final (!(redirect_o === 1'b1 && redirect_pc_o[0] !== 1'b0));

endmodule

//--- rv_id_ex.sv
`timescale 1ns/1ps

module rv_id_ex (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic [rv_pkg::ctrl_w-1:0]     ctrl_i,
    output logic [rv_pkg::ctrl_w-1:0]     ctrl_o,
    input  logic [rv_pkg::xlen-1:0]       rs1_data_i,
    output logic [rv_pkg::xlen-1:0]       rs1_data_o,
    input  logic [rv_pkg::xlen-1:0]       rs2_data_i,
    output logic [rv_pkg::xlen-1:0]       rs2_data_o,
    input  logic                          jump_i,
    output logic                          jump_o,
    input  logic [rv_pkg::xlen-1:0]       pc_plus_i,
    output logic [rv_pkg::xlen-1:0]       pc_plus_o,
    input  logic [rv_pkg::xlen-1:0]       imm_i,
    output logic [rv_pkg::xlen-1:0]       imm_o,
    input  logic [rv_pkg::funct_w-1:0]    funct_i,
    output logic [rv_pkg::funct_w-1:0]    funct_o,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr_i,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr_o,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr_o,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_addr_i,
    output logic [rv_pkg::reg_addr_w-1:0] rd_addr_o
);

    // Stall wins over flush, flush inserts an all-zero bubble
    always_ff @(posedge clk) begin
        if (!rst_n || (flush_i && !stall_i)) begin
            ctrl_o     <= '0;
            rs1_data_o <= '0;
            rs2_data_o <= '0;
            jump_o     <= 1'b0;
            pc_plus_o  <= '0;
            imm_o      <= '0;
            funct_o    <= '0;
            rs1_addr_o <= '0;
            rs2_addr_o <= '0;
            rd_addr_o  <= '0;
        end else if (!stall_i) begin
            ctrl_o     <= ctrl_i;
            rs1_data_o <= rs1_data_i;
            rs2_data_o <= rs2_data_i;
            jump_o     <= jump_i;
            pc_plus_o  <= pc_plus_i;
            imm_o      <= imm_i;
            funct_o    <= funct_i;
            rs1_addr_o <= rs1_addr_i;
            rs2_addr_o <= rs2_addr_i;
            rd_addr_o  <= rd_addr_i;
        end
    end

    flush_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i && !stall_i |=> ctrl_o == '0 && !jump_o);

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable({ctrl_o, rs1_data_o, rs2_data_o, jump_o, pc_plus_o,
                             imm_o, funct_o, rs1_addr_o, rs2_addr_o, rd_addr_o}));

endmodule

//--- rv_id_ex_tb.sv
`timescale 1ns/1ps

module rv_id_ex_tb;

    import rv_pkg::*;

    localparam int drive_delay  = 1;
    localparam int sample_delay = 95;  // Just before the next rising edge
    localparam int edge_limit   = 150;
    localparam int reset_limit  = 10;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        stall;
    logic        flush;
    logic [31:0] wb_data;
    logic [4:0]  rd_addr;
    logic        rd_we;
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic        mem_read;
    logic        mem_write;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    int          seed;

    tb_clk_gen #(.period_ns(100), .reset_cycles(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    rv_id_ex_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .stall_i       (stall),
        .flush_i       (flush),
        .wb_data_o     (wb_data),
        .rd_addr_o     (rd_addr),
        .rd_we_o       (rd_we),
        .mem_addr_o    (mem_addr),
        .store_data_o  (store_data),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr)
    );

    ////////////////////
    // Helpers
    ////////////////////
    task fail_timeout(input string what);
        $display("TIMEOUT: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on timeout");
    endtask

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped on mismatch");
        end
    endtask

    task wait_rise;
        int waited;
        bit seen;
        seen   = 1'b0;
        waited = 0;
        fork
            begin
                @(posedge clk);
                seen = 1'b1;
            end
            while (waited < edge_limit) begin
                #1;
                waited++;
            end
        join_any
        disable fork;
        if (!seen)
            fail_timeout("the clock stopped toggling");
    endtask

    task apply(input logic [31:0] ins, input logic [31:0] pc_v,
               input logic [31:0] a, input logic [31:0] b);
        wait_rise();
        #drive_delay;
        instr    = ins;
        pc       = pc_v;
        rs1_data = a;
        rs2_data = b;
    endtask

    task capture;
        wait_rise();
        #sample_delay;
    endtask

    task check_wb(input logic [31:0] exp_wb, input logic [4:0] exp_rd, input logic exp_we);
        check("wb_data_o", exp_wb, wb_data);
        check("rd_addr_o", exp_rd, rd_addr);
        check("rd_we_o", exp_we, rd_we);
    endtask

    task check_ctrl_zero;
        check("rd_we_o", 0, rd_we);
        check("mem_read_o", 0, mem_read);
        check("mem_write_o", 0, mem_write);
        check("redirect_o", 0, redirect);
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [4:0] rand_rd;
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];  // Never x0
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            OR:      return a | b;
            AND:     return a & b;
            default: return b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////
    // Tests
    ////////////////////
    task test_reset;
        int guard;
        // A live jump sits at the inputs, only the reset keeps the outputs quiet
        instr = {20'h00010, 5'd1, JAL};
        wait_rise();
        #sample_delay;
        check("rst_n", 0, rst_n);
        check_ctrl_zero();
        guard = 0;
        while (rst_n !== 1'b1) begin
            if (guard == reset_limit)
                fail_timeout("reset was never released");
            wait_rise();
            #sample_delay;
            check_ctrl_zero();
            guard++;
        end
        apply(32'd0, 32'd0, 32'd0, 32'd0);
        capture();
        check_ctrl_zero(); // Input word 0 decodes to a bubble
    endtask

    task test_alu_ops;
        alu_op_e     ops [10];
        logic [2:0]  f3s [10];
        logic        alt [10];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [11:0] imm;
        logic [4:0]  rd;
        int          i;
        ops = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
        f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        for (i = 0; i < 10; i++) begin
            a  = $random(seed);
            b  = $random(seed);
            r  = $random(seed);
            rd = rand_rd();
            apply({alt[i] ? 7'h20 : 7'h00, r[9:5], r[4:0], f3s[i], rd, OP}, 32'h100, a, b);
            capture();
            check_wb(alu_ref(ops[i], a, b), rd, 1'b1);
            check("rs1_addr_o", r[4:0], rs1_addr);
            check("rs2_addr_o", r[9:5], rs2_addr);
            if (ops[i] != SUB) begin
                imm = r[31:20];
                // Shift immediates carry funct7 in their upper bits
                if (f3s[i] == 3'd1 || f3s[i] == 3'd5)
                    imm = {alt[i] ? 7'h20 : 7'h00, r[24:20]};
                apply({imm, r[4:0], f3s[i], rd, OP_IMM}, 32'h104, a, b);
                capture();
                check_wb(alu_ref(ops[i], a, sext12(imm)), rd, 1'b1);
            end
        end
        apply({7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OP}, 32'h108, a, b);
        capture();
        check_wb(a + b, 5'd0, 1'b0);
    endtask

    task test_mem_lui;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  rd;
        int          i;
        for (i = 0; i < 4; i++) begin
            a  = $random(seed);
            b  = $random(seed);
            r  = $random(seed);
            rd = rand_rd();
            apply({r[11:0], 5'd3, 3'b010, rd, LOAD}, 32'h180, a, b);
            capture();
            check("mem_addr_o", a + sext12(r[11:0]), mem_addr);
            check("mem_read_o", 1, mem_read);
            check("mem_write_o", 0, mem_write);
            check("rd_we_o", 1, rd_we);
            apply({r[11:5], 5'd4, 5'd3, 3'b010, r[4:0], STORE}, 32'h184, a, b);
            capture();
            check("mem_addr_o", a + sext12(r[11:0]), mem_addr);
            check("store_data_o", b, store_data);
            check("mem_write_o", 1, mem_write);
            check("mem_read_o", 0, mem_read);
            check("rd_we_o", 0, rd_we);
            apply({r[31:12], rd, LUI}, 32'h188, a, b);
            capture();
            check_wb({r[31:12], 12'h000}, rd, 1'b1);
        end
    endtask

    task test_control_flow;
        logic [2:0]  f3s [6];
        logic [31:0] op_a [3];
        logic [31:0] op_b [3];
        logic [31:0] pc_v;
        logic [31:0] off;
        logic [31:0] r;
        logic [4:0]  rd;
        logic        taken;
        int          i;
        int          j;
        f3s  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        r    = $random(seed);
        // Each branch type sees a taken and a not taken pair among these three
        op_a = '{32'hFFFF_FFFB, 32'd3, r};
        op_b = '{32'd3, 32'hFFFF_FFFB, r};
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 3; j++) begin
                r    = $random(seed);
                pc_v = {r[31:2], 2'b00};
                off  = {{19{r[12]}}, r[12:1], 1'b0};
                apply({off[12], off[10:5], 5'd2, 5'd1, f3s[i], off[4:1], off[11], BRANCH},
                      pc_v, op_a[j], op_b[j]);
                capture();
                taken = branch_ref(f3s[i], op_a[j], op_b[j]);
                check("redirect_o", taken, redirect);
                if (taken)
                    check("redirect_pc_o", pc_v + off, redirect_pc);
            end
        end
        for (i = 0; i < 3; i++) begin
            r    = $random(seed);
            pc_v = {r[31:2], 2'b00};
            r    = $random(seed);
            off  = {{11{r[20]}}, r[20:1], 1'b0};
            rd   = rand_rd();
            apply({off[20], off[10:1], off[11], off[19:12], rd, JAL}, pc_v, 32'd0, 32'd0);
            capture();
            check("redirect_o", 1, redirect);
            check("redirect_pc_o", pc_v + off, redirect_pc);
            check_wb(pc_v + 32'd4, rd, 1'b1);
            off = $random(seed);
            apply({r[31:20], 5'd5, 3'b000, rd, JALR}, pc_v, off, 32'd0);
            capture();
            check("redirect_o", 1, redirect);
            check("redirect_pc_o", (off + sext12(r[31:20])) & 32'hFFFF_FFFE, redirect_pc);
            check_wb(pc_v + 32'd4, rd, 1'b1);
        end
    endtask

    task test_stall_flush;
        logic [31:0] ins_a;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          i;
        a     = $random(seed);
        b     = $random(seed);
        ins_a = {7'h00, 5'd2, 5'd1, 3'b000, 5'd7, OP};
        apply(ins_a, 32'h200, a, b);
        capture();
        check_wb(a + b, 5'd7, 1'b1);
        for (i = 0; i < 2; i++) begin
            r = $random(seed);
            apply({7'h00, 5'd4, 5'd3, 3'b010, 5'd0, STORE}, r, r, ~r);
            stall = 1'b1;
            capture();
            check_wb(a + b, 5'd7, 1'b1); // Still the held add
            check("mem_write_o", 0, mem_write);
        end
        wait_rise();
        #drive_delay;
        stall = 1'b0;
        capture();
        check("mem_write_o", 1, mem_write);
        check("mem_addr_o", r, mem_addr);
        check("store_data_o", ~r, store_data);

        // Flush turns the captured jump into a bubble
        apply({20'h00010, 5'd1, JAL}, 32'h400, a, b);
        flush = 1'b1;
        capture();
        check_ctrl_zero();
        check("wb_data_o", 0, wb_data);
        check("mem_addr_o", 0, mem_addr);
        check("store_data_o", 0, store_data);
        check("redirect_pc_o", 0, redirect_pc);

        apply(ins_a, 32'h200, a, b);
        flush = 1'b0;
        capture();
        check_wb(a + b, 5'd7, 1'b1);
        apply({20'h00010, 5'd1, JAL}, 32'h400, a, b);
        stall = 1'b1;
        flush = 1'b1;
        capture();
        check_wb(a + b, 5'd7, 1'b1);
        check("redirect_o", 0, redirect);
        wait_rise();
        #drive_delay;
        stall = 1'b0;
        flush = 1'b0;
        instr = '0;
    endtask

    initial begin
        seed     = 40;
        instr    = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        test_reset();
        test_alu_ops();
        test_mem_lui();
        test_control_flow();
        test_stall_flush();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- rv_id_ex_top.sv
`timescale 1ns/1ps

module rv_id_ex_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::xlen-1:0]       instr_i,
    input  logic [rv_pkg::xlen-1:0]       pc_i,
    input  logic [rv_pkg::xlen-1:0]       rs1_data_i,
    input  logic [rv_pkg::xlen-1:0]       rs2_data_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    output logic [rv_pkg::xlen-1:0]       wb_data_o,
    output logic [rv_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic                          rd_we_o,
    output logic [rv_pkg::xlen-1:0]       mem_addr_o,
    output logic [rv_pkg::xlen-1:0]       store_data_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic                          redirect_o,
    output logic [rv_pkg::xlen-1:0]       redirect_pc_o,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr_o
);

    import rv_pkg::*;

    ////////////////////
    // ID stage
    ////////////////////
    logic [ctrl_w-1:0]     dec_ctrl;
    logic                  dec_jump;
    logic [xlen-1:0]       dec_pc_plus;
    logic [xlen-1:0]       dec_imm;
    logic [funct_w-1:0]    dec_funct;
    logic [reg_addr_w-1:0] dec_rs1_addr;
    logic [reg_addr_w-1:0] dec_rs2_addr;
    logic [reg_addr_w-1:0] dec_rd_addr;

    rv_decoder u_decoder (
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .ctrl_o     (dec_ctrl),
        .jump_o     (dec_jump),
        .pc_plus_o  (dec_pc_plus),
        .imm_o      (dec_imm),
        .funct_o    (dec_funct),
        .rs1_addr_o (dec_rs1_addr),
        .rs2_addr_o (dec_rs2_addr),
        .rd_addr_o  (dec_rd_addr)
    );

    ////////////////////
    // ID/EX register
    ////////////////////
    logic [ctrl_w-1:0]     ex_ctrl;
    logic [xlen-1:0]       ex_rs1_data;
    logic [xlen-1:0]       ex_rs2_data;
    logic                  ex_jump;
    logic [xlen-1:0]       ex_pc_plus;
    logic [xlen-1:0]       ex_imm;
    logic [funct_w-1:0]    ex_funct;
    logic [reg_addr_w-1:0] ex_rd_addr;

    rv_id_ex u_id_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .ctrl_i     (dec_ctrl),
        .ctrl_o     (ex_ctrl),
        .rs1_data_i (rs1_data_i),
        .rs1_data_o (ex_rs1_data),
        .rs2_data_i (rs2_data_i),
        .rs2_data_o (ex_rs2_data),
        .jump_i     (dec_jump),
        .jump_o     (ex_jump),
        .pc_plus_i  (dec_pc_plus),
        .pc_plus_o  (ex_pc_plus),
        .imm_i      (dec_imm),
        .imm_o      (ex_imm),
        .funct_i    (dec_funct),
        .funct_o    (ex_funct),
        .rs1_addr_i (dec_rs1_addr),
        .rs1_addr_o (rs1_addr_o), // Seen by the external hazard unit
        .rs2_addr_i (dec_rs2_addr),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_i  (dec_rd_addr),
        .rd_addr_o  (ex_rd_addr)
    );

    ////////////////////
    // EX stage
    ////////////////////
    logic [xlen-1:0] alu_result;
    logic            br_taken;
    logic [xlen-1:0] br_target;

    rv_alu u_alu (
        .ctrl_i     (ex_ctrl),
        .funct_i    (ex_funct),
        .rs1_data_i (ex_rs1_data),
        .rs2_data_i (ex_rs2_data),
        .imm_i      (ex_imm),
        .result_o   (alu_result)
    );

    rv_branch_unit u_branch_unit (
        .ctrl_i     (ex_ctrl),
        .jump_i     (ex_jump),
        .funct_i    (ex_funct),
        .rs1_data_i (ex_rs1_data),
        .rs2_data_i (ex_rs2_data),
        .imm_i      (ex_imm),
        .pc_plus_i  (ex_pc_plus),
        .taken_o    (br_taken),
        .target_o   (br_target)
    );

    rv_ex_result u_ex_result (
        .ctrl_i          (ex_ctrl),
        .jump_i          (ex_jump),
        .alu_result_i    (alu_result),
        .pc_plus_i       (ex_pc_plus),
        .rs2_data_i      (ex_rs2_data),
        .branch_target_i (br_target),
        .taken_i         (br_taken),
        .rd_addr_i       (ex_rd_addr),
        .wb_data_o       (wb_data_o),
        .mem_addr_o      (mem_addr_o),
        .store_data_o    (store_data_o),
        .redirect_pc_o   (redirect_pc_o),
        .rd_we_o         (rd_we_o),
        .mem_read_o      (mem_read_o),
        .mem_write_o     (mem_write_o),
        .redirect_o      (redirect_o),
        .rd_addr_o       (rd_addr_o)
    );

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // Datapath width, fixed by RV32I
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    ////////////////////
    // Control word
    ////////////////////
    localparam int ctrl_w = 7;

    localparam int ctrl_reg_write = 0;
    localparam int ctrl_mem_read  = 1;
    localparam int ctrl_mem_write = 2;
    localparam int ctrl_branch    = 3;
    localparam int ctrl_alu_src   = 4; // Operand B comes from the immediate
    localparam int ctrl_jalr      = 5;
    localparam int ctrl_lui       = 6;

    // Funct field is {funct7, funct3}
    localparam int funct_w   = 10;
    localparam int funct3_lo = 0;
    localparam int funct7_hi = 9;

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

endpackage

//--- rv_slice.f
rv_pkg.sv
rv_decoder.sv
rv_id_ex.sv
rv_alu.sv
rv_branch_unit.sv
rv_ex_result.sv
rv_id_ex_top.sv
tb_clk_gen.sv
rv_id_ex_tb.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset is released just after the last reset edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule
